/* wb_stage.f */
+incdir+logic
logic/wb_pkg.sv
logic/commit_if.sv
logic/writeback_mux.sv
logic/exception_commit.sv
logic/load_wait_fsm.sv
logic/retire_counter.sv
logic/wb_stage.sv
bench/tb_clock.sv
bench/wb_checker.sv
bench/tb_wb_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the wb_stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module tb_wb_stage \
    -f wb_stage.f \
    --Mdir obj_dir -o tb_wb_stage_sim

./obj_dir/tb_wb_stage_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* bench/tb_wb_stage.sv */
`include "wb_config.svh"

module tb_wb_stage import wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_STALL    = 6;
    localparam int N_DIRECTED   = 80;
    localparam int N_RANDOM     = 400;
    localparam int MARGIN       = 20;
    // worst case, every random op stalls to the limit
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_DIRECTED
                                     + N_RANDOM * (MAX_STALL + 1) + MARGIN;

    logic                  clk, aresetn;
    op_class_e             op0;
    ecode_e                ecode_in, ecode;
    logic                  result1_valid, dcache_ready, csr_ready, exc_in, cpu_interrupt;
    logic [`WB_REG_W-1:0]  rd0, rd1, dcache_rd, wb_rd0, wb_rd1, wb_rd2;
    logic [`WB_DATA_W-1:0] result0, pc0, result1, dcache_data, csr_data, div_data;
    logic [`WB_DATA_W-1:0] badv_in, eentry, tlbrentry;
    logic [`WB_DATA_W-1:0] wb_data0, wb_data1, wb_data2, badv, era, redirect_pc;
    logic                  wb_we0, wb_we1, wb_we2, allowin, exc_flag, tlb_refill;
    logic                  wen_badv, wen_vppn, wen_era, flush_all;
    logic [`WB_VPPN_W-1:0] vppn;
    logic [`WB_CNT_W-1:0]  instret;

    int          seed;
    logic [31:0] w;
    int          idx;
    ecode_e      codes [10] = '{EXP_INT, EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME,
                                EXP_PPI, EXP_ADEF, EXP_ALE, EXP_TLBR, EXP_SYS};

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_tb_clock (
        .clk     (clk),
        .aresetn (aresetn)
    );

    wb_stage u_wb_stage (.*);

    wb_checker u_wb_checker (.*);

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // fresh payload, control bits untouched
    task automatic randomize_data();
        logic [31:0] r;
        result0 = rand_word();
        pc0 = rand_word();
        result1 = rand_word();
        dcache_data = rand_word();
        csr_data = rand_word();
        div_data = rand_word();
        badv_in = rand_word();
        r = rand_word();
        rd0 = r[`WB_REG_W-1:0];
        rd1 = r[8 +: `WB_REG_W];
        dcache_rd = r[16 +: `WB_REG_W];
    endtask

    task automatic drive_quiet();
        op0 = OP_NONE;
        result1_valid = 1'b0;
        dcache_ready = 1'b0;
        csr_ready = 1'b0;
        exc_in = 1'b0;
        cpu_interrupt = 1'b0;
        ecode_in = EXP_INT;
    endtask

    // hold the current inputs until the stage takes them
    task automatic issue();
        int          waited;
        logic [31:0] r;
        waited = 0;
        @(negedge clk);
        while (!allowin && waited <= MAX_STALL) begin
            @(posedge clk);
            #1;
            waited++;
            r = rand_word();
            // cache answers at random, at the latest after MAX_STALL cycles
            dcache_ready = (waited >= MAX_STALL) || (r[1:0] == 2'b00);
            @(negedge clk);
        end
        if (!allowin) begin
            u_wb_checker.note_failure("allowin stayed low after the data cache answered");
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed = 38;
        eentry = 32'h1c00_8000;
        tlbrentry = 32'h1c00_f000;
        drive_quiet();
        randomize_data();
        wait (aresetn);

        // port 0 sources, csr ready in the first half only
        for (int i = 0; i < 10; i++) begin
            randomize_data();
            op0 = op_class_e'(3'(i % 5));
            csr_ready = (i < 5);
            result1_valid = (i % 2 == 0);
            issue();
        end

        // loads that miss, then one hit beside lane 1
        repeat (3) begin
            drive_quiet();
            randomize_data();
            op0 = OP_LOAD;
            issue();
        end
        drive_quiet();
        randomize_data();
        op0 = OP_LOAD;
        dcache_ready = 1'b1;
        result1_valid = 1'b1;
        issue();

        // each code, then a missing load under the flush
        foreach (codes[i]) begin
            drive_quiet();
            randomize_data();
            op0 = OP_ALU;
            result1_valid = 1'b1;
            exc_in = 1'b1;
            ecode_in = codes[i];
            issue();
            drive_quiet();
            op0 = OP_LOAD;
            issue();
        end
        drive_quiet();
        op0 = OP_DIV;
        cpu_interrupt = 1'b1;
        issue();

        // random mix, no exception together with a load
        repeat (N_RANDOM) begin
            randomize_data();
            w = rand_word();
            op0 = op_class_e'(3'(w % 6));
            result1_valid = w[8];
            csr_ready = w[9];
            dcache_ready = w[10];
            exc_in = (w[13:11] == 3'b000) && (op0 != OP_LOAD);
            cpu_interrupt = (w[17:14] == 4'b0000) && (op0 != OP_LOAD);
            idx = int'(w[31:24]) % 10;
            ecode_in = codes[idx];
            issue();
        end

        // drain so the counter catches up
        drive_quiet();
        repeat (3) issue();
        @(negedge clk);
        #1;
        u_wb_checker.print_summary();
        if (u_wb_checker.total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        u_wb_checker.print_summary();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* bench/wb_checker.sv */
`include "wb_config.svh"

module wb_checker import wb_pkg::*; (
    input logic                  clk,
    input logic                  aresetn,
    input op_class_e             op0,
    input ecode_e                ecode_in,
    input logic                  result1_valid, dcache_ready, csr_ready, exc_in, cpu_interrupt,
    input logic [`WB_REG_W-1:0]  rd0, rd1, dcache_rd, wb_rd0, wb_rd1, wb_rd2,
    input logic [`WB_DATA_W-1:0] result0, pc0, result1, dcache_data, csr_data, div_data,
    input logic [`WB_DATA_W-1:0] badv_in, eentry, tlbrentry,
    input logic [`WB_DATA_W-1:0] wb_data0, wb_data1, wb_data2, badv, era, redirect_pc,
    input logic                  wb_we0, wb_we1, wb_we2, allowin, exc_flag, tlb_refill,
    input logic                  wen_badv, wen_vppn, wen_era, flush_all,
    input ecode_e                ecode,
    input logic [`WB_VPPN_W-1:0] vppn,
    input logic [`WB_CNT_W-1:0]  instret
);
    timeunit 1ns;
    timeprecision 100ps;

    // registered state expected after one edge
    typedef struct packed {
        logic                  we0, we1, we2;
        logic [`WB_DATA_W-1:0] data0, data1, data2;
        logic [`WB_REG_W-1:0]  rd0, rd1, rd2;
        logic                  exc_flag, tlb_refill, wen_badv, wen_vppn, wen_era;
        logic [`WB_ECODE_W-1:0] ecode;
        logic [`WB_DATA_W-1:0] badv, era;
        logic [`WB_VPPN_W-1:0] vppn;
    } expect_t;

    expect_t              exp_q = '0;
    logic                 armed = 1'b0;
    logic                 exp_allowin;
    logic [`WB_CNT_W-1:0] exp_instret = '0;
    int                   err_value = 0;
    int                   err_other = 0;

    // reference model of one writeback cycle, from the current inputs
    function automatic expect_t predict();
        expect_t e;
        logic    exc;
        logic    paged;
        logic    addr_fault;
        e = '0;
        exc = exc_in || cpu_interrupt;
        // translation faults carry a page number too
        paged = ecode_in inside {EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI, EXP_TLBR};
        addr_fault = paged || (ecode_in inside {EXP_ADEF, EXP_ALE});
        case (op0)
            OP_ALU: e.data0 = result0;
            OP_LINK: e.data0 = result0 + 32'd4;
            OP_CSR: e.data0 = csr_data;
            OP_DIV: e.data0 = div_data;
            default: e.data0 = '0;
        endcase
        if (aresetn) begin
            e.we0 = ((op0 == OP_ALU) || (op0 == OP_LINK) || (op0 == OP_DIV)
                    || ((op0 == OP_CSR) && csr_ready)) && !exc;
            e.we1 = result1_valid && !exc;
            // load port ignores the flush
            e.we2 = (op0 == OP_LOAD) && dcache_ready;
            e.exc_flag = exc;
            e.wen_era = exc;
            e.wen_badv = exc_in && addr_fault;
            e.wen_vppn = exc_in && paged;
            e.tlb_refill = exc_in && (ecode_in == EXP_TLBR);
        end
        e.data1 = result1;
        e.data2 = dcache_data;
        e.rd0 = rd0;
        e.rd1 = rd1;
        e.rd2 = dcache_rd;
        e.ecode = ecode_in;
        e.badv = badv_in;
        e.vppn = badv_in[`WB_DATA_W-1 -: `WB_VPPN_W];
        e.era = pc0;
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            err_value++;
            $display("** Error %s expected %0h got %0h at %0t", name, want, got, $time);
        end
    endtask

    task automatic note_failure(input string what);
        err_other++;
        $display("failure at %0t: %s", $time, what);
    endtask

    function automatic int total_errors();
        return err_value + err_other;
    endfunction

    task automatic print_summary();
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
    endtask

    // stall while a load waits, unless the stage is flushing
    assign exp_allowin = !((op0 == OP_LOAD) && !dcache_ready) || exp_q.exc_flag;

    // inputs are stable at the edge
    always @(posedge clk) begin
        // counter sees the enables that were out before this edge
        if (!aresetn) begin
            exp_instret <= '0;
        end else begin
            exp_instret <= exp_instret + `WB_CNT_W'(exp_q.we0) + `WB_CNT_W'(exp_q.we1)
                           + `WB_CNT_W'(exp_q.we2);
        end
        exp_q <= predict();
        armed <= 1'b1;
    end

    // mid cycle, all outputs settled
    always @(negedge clk) begin
        if (armed) begin
            compare_value("wb_we0", 32'(wb_we0), 32'(exp_q.we0));
            compare_value("wb_we1", 32'(wb_we1), 32'(exp_q.we1));
            compare_value("wb_we2", 32'(wb_we2), 32'(exp_q.we2));
            if (exp_q.we0) begin
                compare_value("wb_data0", wb_data0, exp_q.data0);
                compare_value("wb_rd0", 32'(wb_rd0), 32'(exp_q.rd0));
            end
            if (exp_q.we1) begin
                compare_value("wb_data1", wb_data1, exp_q.data1);
                compare_value("wb_rd1", 32'(wb_rd1), 32'(exp_q.rd1));
            end
            if (exp_q.we2) begin
                compare_value("wb_data2", wb_data2, exp_q.data2);
                compare_value("wb_rd2", 32'(wb_rd2), 32'(exp_q.rd2));
            end
            compare_value("exc_flag", 32'(exc_flag), 32'(exp_q.exc_flag));
            compare_value("flush_all", 32'(flush_all), 32'(exp_q.exc_flag));
            compare_value("tlb_refill", 32'(tlb_refill), 32'(exp_q.tlb_refill));
            compare_value("wen_badv", 32'(wen_badv), 32'(exp_q.wen_badv));
            compare_value("wen_vppn", 32'(wen_vppn), 32'(exp_q.wen_vppn));
            compare_value("wen_era", 32'(wen_era), 32'(exp_q.wen_era));
            if (exp_q.exc_flag) compare_value("ecode", 32'(ecode), 32'(exp_q.ecode));
            if (exp_q.wen_badv) compare_value("badv", badv, exp_q.badv);
            if (exp_q.wen_vppn) compare_value("vppn", 32'(vppn), 32'(exp_q.vppn));
            if (exp_q.wen_era) compare_value("era", era, exp_q.era);
            compare_value("redirect_pc", redirect_pc, exp_q.tlb_refill ? tlbrentry : eentry);
            compare_value("allowin", 32'(allowin), 32'(exp_allowin));
            compare_value("instret", instret, exp_instret);
        end
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, same as the other inputs
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 aresetn = 1'b1;
    end

endmodule

/* logic/wb_stage.sv */
`include "wb_config.svh"

module wb_stage import wb_pkg::*; (
    input  logic                   clk,
    input  logic                   aresetn,
    // lane 0
    input  op_class_e              op0,
    input  logic [`WB_DATA_W-1:0]  result0,
    input  logic [`WB_REG_W-1:0]   rd0,
    input  logic [`WB_DATA_W-1:0]  pc0,
    // lane 1, ALU only
    input  logic                   result1_valid,
    input  logic [`WB_DATA_W-1:0]  result1,
    input  logic [`WB_REG_W-1:0]   rd1,
    // data cache return
    input  logic                   dcache_ready,
    input  logic [`WB_DATA_W-1:0]  dcache_data,
    input  logic [`WB_REG_W-1:0]   dcache_rd,
    input  logic                   csr_ready,
    input  logic [`WB_DATA_W-1:0]  csr_data,
    input  logic [`WB_DATA_W-1:0]  div_data,
    input  logic                   exc_in,
    input  ecode_e                 ecode_in,
    input  logic [`WB_DATA_W-1:0]  badv_in,
    input  logic                   cpu_interrupt,
    input  logic [`WB_DATA_W-1:0]  eentry,
    input  logic [`WB_DATA_W-1:0]  tlbrentry,
    // register file write ports
    output logic [`WB_DATA_W-1:0]  wb_data0,
    output logic [`WB_REG_W-1:0]   wb_rd0,
    output logic                   wb_we0,
    output logic [`WB_DATA_W-1:0]  wb_data1,
    output logic [`WB_REG_W-1:0]   wb_rd1,
    output logic                   wb_we1,
    output logic [`WB_DATA_W-1:0]  wb_data2,
    output logic [`WB_REG_W-1:0]   wb_rd2,
    output logic                   wb_we2,
    output logic                   allowin,
    // CSR commit
    output logic                   exc_flag,
    output logic                   tlb_refill,
    output ecode_e                 ecode,
    output logic [`WB_DATA_W-1:0]  badv,
    output logic                   wen_badv,
    output logic [`WB_VPPN_W-1:0]  vppn,
    output logic                   wen_vppn,
    output logic [`WB_DATA_W-1:0]  era,
    output logic                   wen_era,
    output logic [`WB_DATA_W-1:0]  redirect_pc,
    output logic                   flush_all,
    output logic [`WB_CNT_W-1:0]   instret
);

    commit_if u_commit ();

    writeback_mux u_writeback_mux (
        .clk           (clk),
        .aresetn       (aresetn),
        .op0           (op0),
        .result0       (result0),
        .rd0           (rd0),
        .result1_valid (result1_valid),
        .result1       (result1),
        .rd1           (rd1),
        .dcache_ready  (dcache_ready),
        .dcache_data   (dcache_data),
        .dcache_rd     (dcache_rd),
        .csr_ready     (csr_ready),
        .csr_data      (csr_data),
        .div_data      (div_data),
        .commit        (u_commit.sink),
        .wb_data0      (wb_data0),
        .wb_rd0        (wb_rd0),
        .wb_we0        (wb_we0),
        .wb_data1      (wb_data1),
        .wb_rd1        (wb_rd1),
        .wb_we1        (wb_we1),
        .wb_data2      (wb_data2),
        .wb_rd2        (wb_rd2),
        .wb_we2        (wb_we2)
    );

    exception_commit u_exception_commit (
        .clk           (clk),
        .aresetn       (aresetn),
        .exc_in        (exc_in),
        .ecode_in      (ecode_in),
        .badv_in       (badv_in),
        .cpu_interrupt (cpu_interrupt),
        .pc0           (pc0),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry),
        .commit        (u_commit.source),
        .redirect_pc   (redirect_pc)
    );

    load_wait_fsm u_load_wait_fsm (
        .clk          (clk),
        .aresetn      (aresetn),
        .op0          (op0),
        .dcache_ready (dcache_ready),
        .commit       (u_commit.sink),
        .allowin      (allowin)
    );

    // counts what actually reached the register file
    retire_counter u_retire_counter (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (wb_we0),
        .we1     (wb_we1),
        .we2     (wb_we2),
        .instret (instret)
    );

    assign exc_flag   = u_commit.exc_flag;
    assign tlb_refill = u_commit.tlb_refill;
    assign ecode      = u_commit.ecode;
    assign badv       = u_commit.badv;
    assign wen_badv   = u_commit.wen_badv;
    assign vppn       = u_commit.vppn;
    assign wen_vppn   = u_commit.wen_vppn;
    assign era        = u_commit.era;
    assign wen_era    = u_commit.wen_era;
    // every committed exception flushes the whole pipe
    assign flush_all  = u_commit.exc_flag;

endmodule

/* logic/retire_counter.sv */
`include "wb_config.svh"

module retire_counter (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 we0,
    input  logic                 we1,
    input  logic                 we2,
    output logic [`WB_CNT_W-1:0] instret
);

    // zero to three writes per cycle
    logic [1:0] n_commit;

    assign n_commit = {1'b0, we0} + {1'b0, we1} + {1'b0, we2};

    // wraps at full width
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            instret <= '0;
        end else begin
            instret <= instret + {{(`WB_CNT_W-2){1'b0}}, n_commit};
        end
    end

endmodule

/* logic/load_wait_fsm.sv */
module load_wait_fsm import wb_pkg::*; (
    input  logic      clk,
    input  logic      aresetn,
    input  op_class_e op0,
    input  logic      dcache_ready,
    commit_if.sink    commit,
    output logic      allowin
);

    ldw_state_e state;
    ldw_state_e state_next;
    logic       load_miss;

    // load present but data not back yet
    assign load_miss = (op0 == OP_LOAD) && !dcache_ready;

    always_comb begin
        state_next = state;
        case (state)
            LDW_IDLE: if (load_miss && !commit.exc_flag) state_next = LDW_WAIT;
            // data arrived or the load was flushed
            LDW_WAIT: if (dcache_ready || commit.exc_flag) state_next = LDW_IDLE;
            default: state_next = LDW_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= LDW_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // hold the previous stage, a flush drops the stalled load
    assign allowin = !load_miss || commit.exc_flag;

    // previous stage must keep the load on its outputs while held
    a_wait_holds_load: assert property (
        @(posedge clk) disable iff (!aresetn) (state == LDW_WAIT) |-> (op0 == OP_LOAD)
    );

endmodule

/* logic/exception_commit.sv */
`include "wb_config.svh"

module exception_commit import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic                  exc_in,
    input  ecode_e                ecode_in,
    input  logic [`WB_DATA_W-1:0] badv_in,
    input  logic                  cpu_interrupt,
    input  logic [`WB_DATA_W-1:0] pc0,
    input  logic [`WB_DATA_W-1:0] eentry,
    input  logic [`WB_DATA_W-1:0] tlbrentry,
    commit_if.source              commit,
    output logic [`WB_DATA_W-1:0] redirect_pc
);

    logic set_badv;
    logic set_vppn;

    // address faults carry a bad address
    always_comb begin
        case (ecode_in)
            EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI, EXP_TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            // no translation involved, so no page number
            EXP_ADEF, EXP_ALE: begin
                set_badv = 1'b1;
                set_vppn = 1'b0;
            end
            default: begin
                set_badv = 1'b0;
                set_vppn = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            commit.exc_flag   <= 1'b0;
            commit.tlb_refill <= 1'b0;
            commit.wen_badv   <= 1'b0;
            commit.wen_vppn   <= 1'b0;
            commit.wen_era    <= 1'b0;
        end else begin
            // interrupts commit like exceptions
            commit.exc_flag   <= exc_in || cpu_interrupt;
            commit.wen_era    <= exc_in || cpu_interrupt;
            commit.wen_badv   <= exc_in && set_badv;
            commit.wen_vppn   <= exc_in && set_vppn;
            commit.tlb_refill <= exc_in && (ecode_in == EXP_TLBR);
        end
    end

    // values only matter with their enables
    always_ff @(posedge clk) begin
        commit.ecode <= ecode_in;
        commit.badv  <= badv_in;
        commit.vppn  <= badv_in[`WB_DATA_W-1 -: `WB_VPPN_W];
        commit.era   <= pc0;
    end

    // refill goes to its own handler
    assign redirect_pc = commit.tlb_refill ? tlbrentry : eentry;

    a_refill_is_exc: assert property (
        @(posedge clk) disable iff (!aresetn) commit.tlb_refill |-> commit.exc_flag
    );

endmodule

/* logic/writeback_mux.sv */
`include "wb_config.svh"

module writeback_mux import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  aresetn,
    input  op_class_e             op0,
    input  logic [`WB_DATA_W-1:0] result0,
    input  logic [`WB_REG_W-1:0]  rd0,
    input  logic                  result1_valid,
    input  logic [`WB_DATA_W-1:0] result1,
    input  logic [`WB_REG_W-1:0]  rd1,
    input  logic                  dcache_ready,
    input  logic [`WB_DATA_W-1:0] dcache_data,
    input  logic [`WB_REG_W-1:0]  dcache_rd,
    input  logic                  csr_ready,
    input  logic [`WB_DATA_W-1:0] csr_data,
    input  logic [`WB_DATA_W-1:0] div_data,
    commit_if.sink                commit,
    output logic [`WB_DATA_W-1:0] wb_data0,
    output logic [`WB_REG_W-1:0]  wb_rd0,
    output logic                  wb_we0,
    output logic [`WB_DATA_W-1:0] wb_data1,
    output logic [`WB_REG_W-1:0]  wb_rd1,
    output logic                  wb_we1,
    output logic [`WB_DATA_W-1:0] wb_data2,
    output logic [`WB_REG_W-1:0]  wb_rd2,
    output logic                  wb_we2
);

    logic [`WB_DATA_W-1:0] sel_data0;
    logic                  sel_we0;
    logic                  we0_q;
    logic                  we1_q;

    // port 0 source by op class
    always_comb begin
        sel_data0 = result0;
        sel_we0   = 1'b0;
        case (op0)
            OP_ALU: sel_we0 = 1'b1;
            OP_LINK: begin
                // link register gets the return address
                sel_data0 = result0 + `WB_DATA_W'd4;
                sel_we0   = 1'b1;
            end
            OP_CSR: begin
                sel_data0 = csr_data;
                sel_we0   = csr_ready;
            end
            OP_DIV: begin
                sel_data0 = div_data;
                sel_we0   = 1'b1;
            end
            // loads leave through port 2
            default: sel_we0 = 1'b0;
        endcase
    end

    // write enables
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            we0_q  <= 1'b0;
            we1_q  <= 1'b0;
            wb_we2 <= 1'b0;
        end else begin
            we0_q  <= sel_we0;
            we1_q  <= result1_valid;
            wb_we2 <= (op0 == OP_LOAD) && dcache_ready;
        end
    end

    // payload, meaningful only with its enable
    always_ff @(posedge clk) begin
        wb_data0 <= sel_data0;
        wb_rd0   <= rd0;
        wb_data1 <= result1;
        wb_rd1   <= rd1;
        wb_data2 <= dcache_data;
        wb_rd2   <= dcache_rd;
    end

    // committing exception kills both lanes in the same cycle
    assign wb_we0 = we0_q && !commit.exc_flag;
    assign wb_we1 = we1_q && !commit.exc_flag;

    // a lane 0 op owns either port 0 or port 2, never both
    a_port0_port2_excl: assert property (
        @(posedge clk) disable iff (!aresetn) !(wb_we0 && wb_we2)
    );

endmodule

/* logic/commit_if.sv */
`include "wb_config.svh"

interface commit_if import wb_pkg::*;;

    // registered exception commit
    logic                   exc_flag;
    logic                   tlb_refill;
    ecode_e                 ecode;
    // bad address and its page number
    logic [`WB_DATA_W-1:0]  badv;
    logic                   wen_badv;
    logic [`WB_VPPN_W-1:0]  vppn;
    logic                   wen_vppn;
    // return address of the faulting instruction
    logic [`WB_DATA_W-1:0]  era;
    logic                   wen_era;

    modport source (
        output exc_flag, tlb_refill, ecode, badv, wen_badv,
        output vppn, wen_vppn, era, wen_era
    );

    // consumers only need the flush
    modport sink (input exc_flag);

endinterface

/* logic/wb_pkg.sv */
`include "wb_config.svh"

package wb_pkg;

    // lane 0 operation class, picks the port 0 source
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_ALU  = 3'd1,
        OP_LINK = 3'd2,
        OP_CSR  = 3'd3,
        OP_DIV  = 3'd4,
        OP_LOAD = 3'd5
    } op_class_e;

    // exception causes, encoded as the ESTAT ecode field
    typedef enum logic [`WB_ECODE_W-1:0] {
        EXP_INT  = 7'h00,
        EXP_PIL  = 7'h01,
        EXP_PIS  = 7'h02,
        EXP_PIF  = 7'h03,
        EXP_PME  = 7'h04,
        EXP_PPI  = 7'h07,
        EXP_ADEF = 7'h08,
        EXP_ALE  = 7'h09,
        EXP_SYS  = 7'h0b,
        // refill has its own entry point
        EXP_TLBR = 7'h3f
    } ecode_e;

    // load wait machine
    typedef enum logic {
        LDW_IDLE = 1'b0,
        LDW_WAIT = 1'b1
    } ldw_state_e;

endpackage

/* logic/wb_config.svh */
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// data word width, shared by all write ports
`define WB_DATA_W 32

// register index width, 32 architectural registers
`define WB_REG_W 5

// exception code width as seen by the CSR file
`define WB_ECODE_W 7

// virtual page number slice of the bad address
`define WB_VPPN_W 19

// retired instruction counter width, wraps
`define WB_CNT_W 32

`endif
